//--- rtl/sigmul_pkg.sv
package sigmul_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Fraction field of a binary128 operand
  localparam int NSIG = 112;
  // Significand with the hidden one restored
  localparam int SIG_W = NSIG + 1;
  localparam int PROD_W = 2 * SIG_W;
  // One row per multiplier significand bit
  localparam int PP_ROWS = SIG_W;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline shape
  ////////////////////////////////////////////////////////////////////////////

  // 113 rows need 11 levels of 3:2 reduction to reach two
  localparam int CSA_LEVELS = 11;
  // Levels 3 and 7 end in a register
  localparam logic [CSA_LEVELS-1:0] REG_LEVEL_MASK = 11'b000_1000_1000;
  // Operand register, two tree registers, adder register
  localparam int PIPE_LATENCY = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [NSIG-1:0] frac_t;
  typedef logic [PROD_W-1:0] prod_t;

  typedef struct packed {
    frac_t frac_a;
    frac_t frac_b;
  } sig_pair_t;

  typedef struct packed {
    prod_t sum;
    prod_t carry;
  } cs_pair_t;

  // Each whole group of three rows turns into two
  function automatic int csa_rows_out(int rows_in);
    return rows_in - rows_in / 3;
  endfunction

endpackage

//--- rtl/sigmul_pp_gen.sv
`timescale 1ns/1ps

module sigmul_pp_gen
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  sigmul_pkg::sig_pair_t operands,
  output logic                  rows_valid,
  output sigmul_pkg::prod_t     rows [sigmul_pkg::PP_ROWS]
);

  sigmul_pkg::sig_pair_t           op_q;
  logic [sigmul_pkg::SIG_W-1:0]    sig_a;

  // Operand register
  always_ff @(posedge clk)
  begin
    if (reset)
      rows_valid <= 1'b0;
    else
      rows_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    op_q <= operands;
  end

  // Multiplicand with its hidden one
  assign sig_a = {1'b1, op_q.frac_a};

  // AND array, one row per fraction bit of the multiplier
  for (genvar i = 0; i < sigmul_pkg::NSIG; i++)
  begin : row_g
    assign rows[i] = sigmul_pkg::prod_t'(sig_a & {sigmul_pkg::SIG_W{op_q.frac_b[i]}}) << i;
  end

  // Multiplier hidden bit is always set, so the top row is the multiplicand
  assign rows[sigmul_pkg::PP_ROWS-1] = sigmul_pkg::prod_t'(sig_a) << sigmul_pkg::NSIG;

endmodule

//--- rtl/sigmul_csa_level.sv
`timescale 1ns/1ps

module sigmul_csa_level
#(
  parameter int ROWS_IN    = 3,
  parameter bit REGISTERED = 1'b0
)
(
  input  logic              clk,
  input  logic              reset,
  input  logic              valid_in,
  input  sigmul_pkg::prod_t rows_in  [ROWS_IN],
  output logic              valid_out,
  output sigmul_pkg::prod_t rows_out [sigmul_pkg::csa_rows_out(ROWS_IN)]
);

  localparam int NGRP = ROWS_IN / 3;
  localparam int ROWS_OUT = sigmul_pkg::csa_rows_out(ROWS_IN);
  localparam int NPASS = ROWS_IN - 3 * NGRP;

  sigmul_pkg::prod_t rows_nxt [ROWS_OUT];

  ////////////////////////////////////////////////////////////////////////////
  // Full adders, bitwise over each group of three rows
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NGRP; g++)
  begin : grp_g
    sigmul_pkg::prod_t x, y, z;

    assign x = rows_in[3*g];
    assign y = rows_in[3*g+1];
    assign z = rows_in[3*g+2];

    assign rows_nxt[2*g] = x ^ y ^ z;
    // Carry moves up one weight; bits past the top are dropped
    assign rows_nxt[2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
  end

  // Leftover rows
  for (genvar k = 0; k < NPASS; k++)
  begin : pass_g
    assign rows_nxt[2*NGRP+k] = rows_in[3*NGRP+k];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Optional level register
  ////////////////////////////////////////////////////////////////////////////

  if (REGISTERED)
  begin : reg_g
    always_ff @(posedge clk)
    begin
      if (reset)
        valid_out <= 1'b0;
      else
        valid_out <= valid_in;
    end

    always_ff @(posedge clk)
    begin
      rows_out <= rows_nxt;
    end
  end
  else
  begin : comb_g
    assign valid_out = valid_in;
    assign rows_out = rows_nxt;
  end

endmodule

//--- rtl/sigmul_csa_tree.sv
`timescale 1ns/1ps

module sigmul_csa_tree
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rows_valid,
  input  sigmul_pkg::prod_t    rows [sigmul_pkg::PP_ROWS],
  output logic                 cs_valid,
  output sigmul_pkg::cs_pair_t cs
);

  // Rows entering a given level
  function automatic int level_rows(int lvl);
    int n;
    n = sigmul_pkg::PP_ROWS;
    for (int i = 0; i < lvl; i++)
      n = sigmul_pkg::csa_rows_out(n);
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reduction chain, 113 rows down to 2
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < sigmul_pkg::CSA_LEVELS; l++)
  begin : lvl_g
    localparam int RIN = level_rows(l);
    localparam int ROUT = sigmul_pkg::csa_rows_out(RIN);

    logic              v_in;
    logic              v_out;
    sigmul_pkg::prod_t r_in  [RIN];
    sigmul_pkg::prod_t r_out [ROUT];

    if (l == 0)
    begin : first_g
      assign v_in = rows_valid;
      assign r_in = rows;
    end
    else
    begin : next_g
      assign v_in = lvl_g[l-1].v_out;
      assign r_in = lvl_g[l-1].r_out;
    end

    sigmul_csa_level #(
      .ROWS_IN    (RIN),
      .REGISTERED (sigmul_pkg::REG_LEVEL_MASK[l])
    ) level_i (
      .clk       (clk),
      .reset     (reset),
      .valid_in  (v_in),
      .rows_in   (r_in),
      .valid_out (v_out),
      .rows_out  (r_out)
    );
  end

  // Last level leaves exactly one sum and one carry row
  assign cs_valid = lvl_g[sigmul_pkg::CSA_LEVELS-1].v_out;
  assign cs.sum = lvl_g[sigmul_pkg::CSA_LEVELS-1].r_out[0];
  assign cs.carry = lvl_g[sigmul_pkg::CSA_LEVELS-1].r_out[1];

endmodule

//--- rtl/sigmul_cpa.sv
`timescale 1ns/1ps

module sigmul_cpa
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cs_valid,
  input  sigmul_pkg::cs_pair_t cs,
  output logic                 out_valid,
  output sigmul_pkg::prod_t    product
);

  localparam int LO_W = sigmul_pkg::PROD_W / 2;
  localparam int HI_W = sigmul_pkg::PROD_W - LO_W;

  logic [LO_W:0]     lo_sum;
  logic [HI_W-1:0]   hi_sum0;
  logic [HI_W-1:0]   hi_sum1;
  sigmul_pkg::prod_t sum_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Carry-select addition
  ////////////////////////////////////////////////////////////////////////////

  // Lower half, with its carry out on top
  assign lo_sum = {1'b0, cs.sum[LO_W-1:0]} + {1'b0, cs.carry[LO_W-1:0]};

  // Upper half for both possible carries in
  assign hi_sum0 = cs.sum[sigmul_pkg::PROD_W-1:LO_W] + cs.carry[sigmul_pkg::PROD_W-1:LO_W];
  assign hi_sum1 = hi_sum0 + HI_W'(1);

  assign sum_nxt = lo_sum[LO_W] ? {hi_sum1, lo_sum[LO_W-1:0]}
                                : {hi_sum0, lo_sum[LO_W-1:0]};

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
      out_valid <= 1'b0;
    else
      out_valid <= cs_valid;
  end

  always_ff @(posedge clk)
  begin
    product <= sum_nxt;
  end

endmodule

//--- rtl/sigmul_top.sv
`timescale 1ns/1ps

module sigmul_top
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  sigmul_pkg::sig_pair_t operands,
  output logic                  out_valid,
  output sigmul_pkg::prod_t     product
);

  logic                 rows_valid;
  sigmul_pkg::prod_t    rows [sigmul_pkg::PP_ROWS];
  logic                 cs_valid;
  sigmul_pkg::cs_pair_t cs;

  // Operand register and partial products
  sigmul_pp_gen sigmul_pp_gen_i (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .operands   (operands),
    .rows_valid (rows_valid),
    .rows       (rows)
  );

  // Carry-save reduction, two register stages
  sigmul_csa_tree sigmul_csa_tree_i (
    .clk        (clk),
    .reset      (reset),
    .rows_valid (rows_valid),
    .rows       (rows),
    .cs_valid   (cs_valid),
    .cs         (cs)
  );

  sigmul_cpa sigmul_cpa_i (
    .clk       (clk),
    .reset     (reset),
    .cs_valid  (cs_valid),
    .cs        (cs),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule

//--- sim/sigmul_chk.sv
`timescale 1ns/1ps

module sigmul_chk
(
  input logic              clk,
  input logic              reset,
  input logic              in_valid,
  input logic              out_valid,
  input sigmul_pkg::prod_t product
);

  // Reset as seen at each of the last PIPE_LATENCY edges
  logic [sigmul_pkg::PIPE_LATENCY-1:0] rst_hist = '1;

  always @(posedge clk)
  begin
    rst_hist <= {rst_hist[sigmul_pkg::PIPE_LATENCY-2:0], reset};
  end

  a_idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  a_latency: assert property (@(posedge clk)
    (rst_hist == '0) |-> (out_valid == $past(in_valid, sigmul_pkg::PIPE_LATENCY)))
    else $error("out_valid does not follow in_valid by the pipeline latency");

  a_known_product: assert property (@(posedge clk) out_valid |-> !$isunknown(product))
    else $error("product has unknown bits while out_valid is high");

endmodule

bind sigmul_top sigmul_chk sigmul_chk_i (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .product   (product)
);

//--- sim/sigmul_tb.sv
`timescale 1ns/1ps

module sigmul_tb;

  localparam int RESET_CYCLES = 4;
  localparam int N_RAND = 1000;
  localparam int N_MID = 40;
  // About 2,100 strobes; the sparse test spreads its 1,000 over ~2,000 cycles,
  // plus drains, the mid-stream reset and latency margin
  localparam int CYCLE_LIMIT = 5000;

  typedef struct packed {
    sigmul_pkg::prod_t value;
    logic [31:0]       cycle;
  } exp_t;

  logic                  clk;
  logic                  reset;
  logic                  in_valid;
  sigmul_pkg::sig_pair_t operands;
  logic                  out_valid;
  sigmul_pkg::prod_t     product;

  integer      seed = 32'h4d44_5b69;
  int unsigned cycle = 0;
  int          err_count = 0;
  int          test_errs;
  int          test_ops;
  int          tests_passed = 0;
  int          tests_failed = 0;
  string       test_name;
  exp_t        exp_q [$];

  sigmul_top sigmul_top_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .operands  (operands),
    .out_valid (out_valid),
    .product   (product)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////////////////////////////////////////

  // (2^112 + a) * (2^112 + b) at full width
  function automatic sigmul_pkg::prod_t ref_product(sigmul_pkg::frac_t a,
                                                    sigmul_pkg::frac_t b);
    sigmul_pkg::prod_t x;
    sigmul_pkg::prod_t y;
    x = '0;
    y = '0;
    x[sigmul_pkg::NSIG] = 1'b1;
    y[sigmul_pkg::NSIG] = 1'b1;
    x[sigmul_pkg::NSIG-1:0] = a;
    y[sigmul_pkg::NSIG-1:0] = b;
    return x * y;
  endfunction

  function automatic sigmul_pkg::sig_pair_t rand_pair();
    logic [127:0]          ra;
    logic [127:0]          rb;
    sigmul_pkg::sig_pair_t p;
    ra = {$random(seed), $random(seed), $random(seed), $random(seed)};
    rb = {$random(seed), $random(seed), $random(seed), $random(seed)};
    p.frac_a = ra[sigmul_pkg::NSIG-1:0];
    p.frac_b = rb[sigmul_pkg::NSIG-1:0];
    return p;
  endfunction

  task automatic count_error();
    err_count++;
    test_errs++;
  endtask

  task automatic check_output();
    exp_t e;
    if (out_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("%s: output strobe at cycle %0d with no matching input", test_name, cycle);
        count_error();
      end
      else
      begin
        e = exp_q.pop_front();
        if (product !== e.value)
        begin
          $display("ERR %s: expected %h, actual %h", test_name, e.value, product);
          count_error();
        end
        if (cycle != e.cycle + sigmul_pkg::PIPE_LATENCY)
        begin
          $display("ERR %s: expected output cycle %0d, actual %0d", test_name,
                   e.cycle + sigmul_pkg::PIPE_LATENCY, cycle);
          count_error();
        end
        if (product[sigmul_pkg::PROD_W-1 -: 2] == 2'b00)
        begin
          $display("ERR %s: expected product >= 2^224, actual %h", test_name, product);
          count_error();
        end
      end
    end
  endtask

  // Outputs are checked before the new inputs go out on the same falling edge
  task automatic drive_cycle(input logic v, input sigmul_pkg::sig_pair_t ops,
                             input logic rst);
    exp_t e;
    @(negedge clk);
    check_output();
    reset = rst;
    in_valid = v;
    operands = ops;
    if (rst)
      exp_q.delete();
    else if (v)
    begin
      e.value = ref_product(ops.frac_a, ops.frac_b);
      e.cycle = cycle;
      exp_q.push_back(e);
      test_ops++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
    test_ops = 0;
  endtask

  task automatic end_test();
    while (exp_q.size() != 0)
      drive_cycle(1'b0, rand_pair(), 1'b0);
    // Extra idle cycles catch stray strobes
    repeat (2)
      drive_cycle(1'b0, rand_pair(), 1'b0);
    if (test_errs == 0)
    begin
      tests_passed++;
      $display("PASS %s: %0d operations", test_name, test_ops);
    end
    else
    begin
      tests_failed++;
      $display("FAIL %s: %0d operations, %0d errors", test_name, test_ops, test_errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int                    r;
    sigmul_pkg::sig_pair_t p;
    reset = 1'b1;
    in_valid = 1'b0;
    operands = '0;
    repeat (RESET_CYCLES) @(posedge clk);

    begin_test("corners");
    p.frac_a = '0;
    p.frac_b = '0;
    drive_cycle(1'b1, p, 1'b0);
    p.frac_a = '1;
    p.frac_b = '1;
    drive_cycle(1'b1, p, 1'b0);
    end_test();

    begin_test("back_to_back");
    repeat (N_RAND)
      drive_cycle(1'b1, rand_pair(), 1'b0);
    end_test();

    begin_test("sparse");
    while (test_ops < N_RAND)
    begin
      r = $random(seed);
      drive_cycle(r[0], rand_pair(), 1'b0);
    end
    end_test();

    begin_test("mid_reset");
    repeat (N_MID)
      drive_cycle(1'b1, rand_pair(), 1'b0);
    // One reset cycle while the stream keeps strobing
    drive_cycle(1'b1, rand_pair(), 1'b1);
    // Pipe is empty now, any strobe here is stale
    repeat (2 * sigmul_pkg::PIPE_LATENCY)
      drive_cycle(1'b0, rand_pair(), 1'b0);
    repeat (N_MID)
      drive_cycle(1'b1, rand_pair(), 1'b0);
    end_test();

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             err_count);
    if (err_count == 0 && tests_failed == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- all.f
rtl/sigmul_pkg.sv
rtl/sigmul_pp_gen.sv
rtl/sigmul_csa_level.sv
rtl/sigmul_csa_tree.sv
rtl/sigmul_cpa.sv
rtl/sigmul_top.sv
sim/sigmul_chk.sv
sim/sigmul_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sigmul_tb
FILELIST = all.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuild only when a listed source or the list itself changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
